/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := input_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard src/*.sv src/*.svh dv/*.sv)
PASS_MSG := TEST RESULT: PASS
FAIL_MSG := TEST RESULT: FAIL

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/input_checker.sv */
// ------------------------------
// input front end assertions
// load strobe timing, event strobes, reset state
// ------------------------------

`timescale 1ns/100ps
`include "input_cfg.svh"
`default_nettype none

module input_checker (
  input wire logic           ena_x,
  input wire logic           pll_lckd,
  input wire logic           joy_load,
  input wire logic           valid,
  input wire logic           err,
  input wire joy_pkg::ctrl_t ctrl
);
  import joy_pkg::*;

  localparam ctrl_t ctrl_idle = '{joy_a: '1, joy_b: '1, start: '1, coin: '1, reset_req: 1'b0};

  int         fails = 0;
  logic       load_q;
  logic       load_fell;
  logic       seen;
  logic [5:0] gap;
  logic       in_rst = 1'b0;

  assign load_fell = load_q & ~joy_load;

  // cycles since the last falling load strobe
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      load_q <= 1'b1;
      seen   <= 1'b0;
      gap    <= '0;
    end else begin
      load_q <= joy_load;
      if (load_fell) begin
        gap  <= 6'd1;
        seen <= 1'b1;
      end else if (gap != 6'h3F) begin
        gap <= gap + 1'b1;
      end
    end
  end

  always @(posedge ena_x) begin
    in_rst <= !pll_lckd;
  end

  load_single: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |=> joy_load)
    else begin
      $error("load strobe low for two cycles");
      fails++;
    end

  load_period: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    seen && load_fell |-> gap == 6'(`JOY_FRAME_LEN))
    else begin
      $error("load strobe period is %0d cycles", gap);
      fails++;
    end

  evt_excl: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !(valid && err))
    else begin
      $error("valid and err strobes high together");
      fails++;
    end

  rst_ctrl: assert property (@(posedge ena_x)
    in_rst && !pll_lckd |-> ctrl == ctrl_idle)
    else begin
      $error("ctrl not inactive during reset");
      fails++;
    end

endmodule

bind joy_serial_rx input_checker u_chk_joy (
  .ena_x    (ena_x),
  .pll_lckd (pll_lckd),
  .joy_load (joy_load),
  .valid    (1'b0),
  .err      (1'b0),
  .ctrl     (17'h1FFFE)
);

bind arcade_ctrl_map input_checker u_chk_map (
  .ena_x    (ena_x),
  .pll_lckd (pll_lckd),
  .joy_load (1'b1),
  .valid    (evt.valid),
  .err      (evt.err),
  .ctrl     (ctrl)
);

`default_nettype wire

/* dv/input_tb.sv */
// ------------------------------
// input front end testbench
// shift chain and PS/2 keyboard models,
// table driven rows with computed expectations
// ------------------------------

`timescale 1ns/100ps
`include "input_cfg.svh"
`default_nettype none

module input_tb;
  import joy_pkg::*;
  import kbd_pkg::*;

  localparam int clk_period  = 10;
  localparam int n_rows      = 10;
  localparam int ps2_half    = 8;
  localparam int ps2_gap     = 20;
  localparam int byte_cycles = `PS2_FRAME_BITS * (2 * ps2_half + 1) + ps2_gap;
  localparam int wd_cycles   = (n_rows * 2 * `JOY_FRAME_LEN + n_rows * 3 * byte_cycles) * 2;

  // pad bit fed by each serial position
  // pad2 owns positions 8 to 19
  localparam int pos_bit [24] = '{8, 6, 5, 4, 3, 2, 1, 0,
                                  8, 6, 5, 4, 3, 2, 1, 0,
                                  10, 11, 9, 7, 10, 11, 9, 7};

  typedef struct {
    string      name;
    joy_frame_t frame;
    int         n_codes;
    scan_code_t codes [3];
    bit         bad_par;
    logic [1:0] btn;
    pad_pair_t  exp_pads;
    bit         exp_err;
    ctrl_t      exp_ctrl;
  } row_t;

  logic       ena_x;
  logic       pll_lckd;
  logic       joy_data = 1'b1;
  logic       ps2_clk = 1'b1;
  logic       ps2_data = 1'b1;
  logic [1:0] btn = 2'b11;
  logic       joy_load;
  logic       kbd_err;
  pad_pair_t  pads;
  ctrl_t      ctrl;

  row_t       rows [n_rows];
  joy_frame_t chain_frame = '1;
  joy_frame_t chain_sr = '1;
  int         chain_pos = 24;
  int         since_load = 0;
  pad_pair_t  pads_q = '1;
  int         err_pulses = 0;
  int         n_checks = 0;
  int         n_err_pads = 0;
  int         n_err_ctrl = 0;
  int         n_err_bit = 0;
  int         n_asrt = 0;
  integer     seed;
  bit         key_down [256];
  bit         brk_pending = 1'b0;

  tb_clk_gen #(.period(clk_period), .rst_cycles(2)) u_clk (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd)
  );

  input_top u_dut (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .joy_load (joy_load),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .btn      (btn),
    .pads     (pads),
    .kbd_err  (kbd_err),
    .ctrl     (ctrl)
  );

  // ------------------------------
  // shift chain model
  // ------------------------------
  always @(posedge ena_x) begin
    if (!joy_load) begin
      chain_sr  <= chain_frame;
      joy_data  <= chain_frame[0];
      chain_pos <= 1;
    end else if (chain_pos < 24) begin
      joy_data  <= chain_sr[chain_pos];
      chain_pos <= chain_pos + 1;
    end else begin
      joy_data <= 1'b1;
    end
  end

  // both pad words change only on the last step of a frame
  always @(negedge ena_x) begin
    if (!joy_load) begin
      since_load = 0;
    end else begin
      since_load = since_load + 1;
    end
    if (pads !== pads_q && since_load != `JOY_FRAME_LEN - 1) begin
      n_err_pads++;
      $display("pads changed %0d cycles after the load strobe instead of on the last step",
               since_load);
    end
    pads_q = pads;
  end

  always @(posedge ena_x) begin
    if (kbd_err) begin
      err_pulses <= err_pulses + 1;
    end
  end

  // start, data lsb first, odd parity, stop
  task automatic send_ps2(input scan_code_t code, input bit bad_par);
    logic [10:0] bits;
    bits = {1'b1, (~^code) ^ bad_par, code, 1'b0};
    for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
      @(posedge ena_x);
      ps2_data <= bits[i];
      repeat (ps2_half) @(posedge ena_x);
      ps2_clk <= 1'b0;
      repeat (ps2_half) @(posedge ena_x);
      ps2_clk <= 1'b1;
    end
    repeat (ps2_gap) @(posedge ena_x);
  endtask

  // ------------------------------
  // expected values
  // ------------------------------
  function automatic pad_pair_t exp_pads_of(input joy_frame_t f);
    pad_pair_t p;
    p = '1;
    for (int j = 0; j < 24; j++) begin
      if (j >= 8 && j < 20) begin
        p.pad2[pos_bit[j]] = f[j];
      end else begin
        p.pad1[pos_bit[j]] = f[j];
      end
    end
    return p;
  endfunction

  function automatic void key_event(input scan_code_t code);
    if (code == sc_break) begin
      brk_pending = 1'b1;
    end else if (code != sc_ext) begin
      key_down[code] = !brk_pending;
      brk_pending = 1'b0;
    end
  endfunction

  function automatic ctrl_t exp_ctrl_of(input pad_pair_t p, input logic [1:0] b);
    ctrl_t c;
    c.joy_a = p.pad1[5:0];
    if (key_down[sc_up])    c.joy_a[0] = 1'b0;
    if (key_down[sc_down])  c.joy_a[1] = 1'b0;
    if (key_down[sc_left])  c.joy_a[2] = 1'b0;
    if (key_down[sc_right]) c.joy_a[3] = 1'b0;
    if (key_down[sc_space]) c.joy_a[4] = 1'b0;
    c.joy_b     = p.pad2[5:0];
    c.start[0]  = p.pad1[8] & !key_down[sc_key1];
    c.start[1]  = p.pad2[8] & !key_down[sc_key2];
    c.coin[0]   = p.pad1[9] & b[0] & !key_down[sc_key5];
    c.coin[1]   = p.pad2[9];
    c.reset_req = key_down[sc_f3] | !p.pad1[11] | !b[1];
    return c;
  endfunction

  // rel forces positions released
  // clr forces positions pressed
  task automatic add_row(input int idx, input string name, input int n,
                         input scan_code_t c0, input scan_code_t c1, input scan_code_t c2,
                         input bit bad, input logic [1:0] b,
                         input joy_frame_t rel, input joy_frame_t clr);
    row_t r;
    r.name     = name;
    r.n_codes  = n;
    r.codes    = '{c0, c1, c2};
    r.bad_par  = bad;
    r.btn      = b;
    r.frame    = (joy_frame_t'($random(seed)) | rel) & ~clr;
    r.exp_pads = exp_pads_of(r.frame);
    if (!bad) begin
      for (int k = 0; k < n; k++) begin
        key_event(r.codes[k]);
      end
    end
    r.exp_err  = bad;
    r.exp_ctrl = exp_ctrl_of(r.exp_pads, b);
    rows[idx]  = r;
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_pads(input string name, input pad_pair_t exp, input pad_pair_t act);
    n_checks++;
    if (act !== exp) begin
      n_err_pads++;
      $display("ERROR %s pads expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
    n_checks++;
    if (act !== exp) begin
      n_err_ctrl++;
      $display("ERROR %s ctrl expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input bit exp, input bit act);
    n_checks++;
    if (act !== exp) begin
      n_err_bit++;
      $display("ERROR %s kbd_err pulse expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_err_bit++;
      $display("ERROR %s level expected %b actual %b", name, exp, act);
    end
  endtask

  // edge on which the chain model latches a frame
  task automatic wait_load();
    @(posedge ena_x);
    while (joy_load !== 1'b0) begin
      @(posedge ena_x);
    end
  endtask

  initial begin
    #(wd_cycles * clk_period);
    $display("watchdog expired after %0d cycles, DUT made no progress", wd_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int base;
    int total;
    seed = 32'h997f3e39;
    add_row(0, "random_a", 0, 8'h00, 8'h00, 8'h00, 1'b0, 2'b11, 24'h200000, 24'h0);
    add_row(1, "random_b", 0, 8'h00, 8'h00, 8'h00, 1'b0, 2'b11, 24'h200000, 24'h0);
    add_row(2, "key_make_a", 3, sc_up, sc_space, sc_key1, 1'b0, 2'b11, 24'h2000FF, 24'h0);
    add_row(3, "key_make_b", 3, sc_left, sc_key2, sc_key5, 1'b0, 2'b11, 24'h6001FF, 24'h0);
    add_row(4, "key_break", 3, sc_break, sc_up, sc_down, 1'b0, 2'b11, 24'h2000FF, 24'h0);
    add_row(5, "parity_err", 1, sc_right, 8'h00, 8'h00, 1'b1, 2'b11, 24'h2000FF, 24'h0);
    add_row(6, "reset_f3", 1, sc_f3, 8'h00, 8'h00, 1'b0, 2'b11, 24'h2000FF, 24'h0);
    add_row(7, "reset_pad", 2, sc_break, sc_f3, 8'h00, 1'b0, 2'b11, 24'h0000FF, 24'h200000);
    add_row(8, "reset_btn", 2, sc_break, sc_key5, 8'h00, 1'b0, 2'b01, 24'h6000FF, 24'h0);
    add_row(9, "coin_btn", 0, 8'h00, 8'h00, 8'h00, 1'b0, 2'b10, 24'h600000, 24'h0);

    @(posedge pll_lckd);
    check_level("reset_load", 1'b1, joy_load);
    check_pads("reset", '1, pads);
    check_ctrl("reset", '{joy_a: '1, joy_b: '1, start: '1, coin: '1, reset_req: 1'b0}, ctrl);

    for (int i = 0; i < n_rows; i++) begin
      @(posedge ena_x);
      chain_frame <= rows[i].frame;
      btn         <= rows[i].btn;
      base = err_pulses;
      for (int k = 0; k < rows[i].n_codes; k++) begin
        send_ps2(rows[i].codes[k], rows[i].bad_par);
      end
      repeat (2) wait_load();
      @(negedge ena_x);
      check_pads(rows[i].name, rows[i].exp_pads, pads);
      check_ctrl(rows[i].name, rows[i].exp_ctrl, ctrl);
      check_err(rows[i].name, rows[i].exp_err, err_pulses != base);
    end

    n_asrt = u_dut.u_joy.u_chk_joy.fails + u_dut.u_map.u_chk_map.fails;
    total  = n_err_pads + n_err_ctrl + n_err_bit + n_asrt;
    $display("checks %0d, pad errors %0d, ctrl errors %0d, bit errors %0d, assertion failures %0d",
             n_checks, n_err_pads, n_err_ctrl, n_err_bit, n_asrt);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// ------------------------------
// testbench clock and reset
// free running clock, reset low for a few cycles
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int period     = 10,
  parameter int rst_cycles = 2
) (
  output logic ena_x,
  output logic pll_lckd
);

  initial begin
    ena_x = 1'b0;
    forever #(period / 2) ena_x = ~ena_x;
  end

  // release away from the rising edge
  initial begin
    pll_lckd = 1'b0;
    repeat (rst_cycles) @(posedge ena_x);
    @(negedge ena_x);
    pll_lckd = 1'b1;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/joy_pkg.sv
src/kbd_pkg.sv
src/joy_serial_rx.sv
src/ps2_rx.sv
src/arcade_ctrl_map.sv
src/input_top.sv
dv/tb_clk_gen.sv
dv/input_checker.sv
dv/input_tb.sv

/* src/arcade_ctrl_map.sv */
// ------------------------------
// arcade control mapper
// tracks held keys and merges them with
// pads and board buttons into core controls
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

module arcade_ctrl_map (
  input  wire logic               ena_x,
  input  wire logic               pll_lckd,
  input  wire joy_pkg::pad_pair_t pads,
  input  wire kbd_pkg::kbd_evt_t  evt,
  input  wire logic [1:0]         btn,
  output joy_pkg::ctrl_t          ctrl
);
  import joy_pkg::*;
  import kbd_pkg::*;

  logic      brk;
  key_held_t held;
  key_held_t held_nxt;
  ctrl_t     ctrl_nxt;
  pad_word_t p1;
  pad_word_t p2;

  assign p1 = pads.pad1;
  assign p2 = pads.pad2;

  // make sets, break clears, prefixes leave keys alone
  always_comb begin
    held_nxt = held;
    if (evt.valid && evt.code != sc_break && evt.code != sc_ext) begin
      case (evt.code)
        sc_up:    held_nxt.up    = ~brk;
        sc_down:  held_nxt.down  = ~brk;
        sc_left:  held_nxt.left  = ~brk;
        sc_right: held_nxt.right = ~brk;
        sc_space: held_nxt.space = ~brk;
        sc_key1:  held_nxt.key1  = ~brk;
        sc_key2:  held_nxt.key2  = ~brk;
        sc_key5:  held_nxt.key5  = ~brk;
        sc_f3:    held_nxt.f3    = ~brk;
        default: ;
      endcase
    end
  end

  // ------------------------------
  // merge, all active low but reset_req
  // ------------------------------
  always_comb begin
    ctrl_nxt.joy_a = p1[5:0] & ~{1'b0, held_nxt.space, held_nxt.right,
                                 held_nxt.left, held_nxt.down, held_nxt.up};
    ctrl_nxt.joy_b = p2[5:0];
    ctrl_nxt.start = {p2[8] & ~held_nxt.key2, p1[8] & ~held_nxt.key1};
    // btn 0 doubles as coin 1
    ctrl_nxt.coin      = {p2[9], p1[9] & btn[0] & ~held_nxt.key5};
    ctrl_nxt.reset_req = held_nxt.f3 | ~p1[11] | ~btn[1];
  end

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      brk  <= 1'b0;
      held <= '0;
      ctrl <= '{joy_a: '1, joy_b: '1, start: '1, coin: '1, reset_req: 1'b0};
    end else begin
      if (evt.valid) begin
        if (evt.code == sc_break) begin
          brk <= 1'b1;
        end else if (evt.code != sc_ext) begin
          brk <= 1'b0;
        end
      end
      held <= held_nxt;
      ctrl <= ctrl_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/input_cfg.svh */
// ------------------------------
// input front end configuration
// frame lengths and the PS/2 idle limit
// ------------------------------

`ifndef INPUT_CFG_SVH
`define INPUT_CFG_SVH

// load and shift steps per joystick frame
`define JOY_FRAME_LEN 26

// start, eight data, parity, stop
`define PS2_FRAME_BITS 11

// ena_x cycles without a PS/2 clock edge before a frame is dropped
`define PS2_TIMEOUT 2000

`endif

/* src/input_top.sv */
// ------------------------------
// input front end top level
// joystick chain, PS/2 keyboard, control merge
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

module input_top (
  input  wire logic         ena_x,
  input  wire logic         pll_lckd,
  input  wire logic         joy_data,
  output logic              joy_load,
  input  wire logic         ps2_clk,
  input  wire logic         ps2_data,
  input  wire logic [1:0]   btn,
  output joy_pkg::pad_pair_t pads,
  output logic              kbd_err,
  output joy_pkg::ctrl_t    ctrl
);
  import kbd_pkg::*;

  kbd_evt_t evt;

  joy_serial_rx u_joy (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .joy_load (joy_load),
    .pads     (pads)
  );

  ps2_rx u_ps2 (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .evt      (evt)
  );

  arcade_ctrl_map u_map (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .pads     (pads),
    .evt      (evt),
    .btn      (btn),
    .ctrl     (ctrl)
  );

  assign kbd_err = evt.err;

endmodule

`default_nettype wire

/* src/joy_pkg.sv */
// ------------------------------
// joystick and control types
// pad words, shift frame and core controls
// ------------------------------

`default_nettype none

package joy_pkg;

  // active low, 0 means pressed
  // 5:0 up down left right fire1 fire2, 6 fire3, 7 fire4
  // 8 start, 9 coin, 10 mode, 11 reset
  typedef logic [11:0] pad_word_t;

  // step counter of the load and shift cycle
  typedef logic [4:0] joy_step_t;

  // raw serial positions 0 to 23
  typedef logic [23:0] joy_frame_t;

  typedef struct packed {
    pad_word_t pad1;
    pad_word_t pad2;
  } pad_pair_t;

  // core controls, active low apart from reset_req
  typedef struct packed {
    logic [5:0] joy_a;
    logic [5:0] joy_b;
    logic [1:0] start;
    logic [1:0] coin;
    logic       reset_req;
  } ctrl_t;

endpackage

`default_nettype wire

/* src/joy_serial_rx.sv */
// ------------------------------
// joystick serial receiver
// drives the shift chain load strobe and
// rebuilds both pad words from 24 serial bits
// ------------------------------

`timescale 1ns/100ps
`include "input_cfg.svh"
`default_nettype none

module joy_serial_rx (
  input  wire logic         ena_x,
  input  wire logic         pll_lckd,
  input  wire logic         joy_data,
  output logic              joy_load,
  output joy_pkg::pad_pair_t pads
);
  import joy_pkg::*;

  localparam joy_step_t last_step  = joy_step_t'(`JOY_FRAME_LEN - 1);
  localparam joy_step_t first_smpl = joy_step_t'(2);

  joy_step_t  step;
  joy_frame_t shadow;

  // serial position to pad bit, same order as the board chain
  function automatic pad_pair_t frame_to_pads(input joy_frame_t f);
    pad_pair_t p;
    p.pad1[8] = f[0];
    p.pad2[8] = f[8];
    // positions 1..7 carry fire3 then fire2 down to up
    for (int k = 1; k < 8; k++) begin
      p.pad1[7 - k] = f[k];
      p.pad2[7 - k] = f[k + 8];
    end
    p.pad2[10] = f[16];
    p.pad2[11] = f[17];
    p.pad2[9]  = f[18];
    p.pad2[7]  = f[19];
    p.pad1[10] = f[20];
    p.pad1[11] = f[21];
    p.pad1[9]  = f[22];
    p.pad1[7]  = f[23];
    return p;
  endfunction

  // ------------------------------
  // step counter and load strobe
  // ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      step     <= '0;
      joy_load <= 1'b1;
    end else begin
      // low for the single cycle after step 0
      joy_load <= (step != '0);
      if (step == last_step) begin
        step <= '0;
      end else begin
        step <= step + 1'b1;
      end
    end
  end

  // ------------------------------
  // sampling and publication
  // ------------------------------
  always_ff @(posedge ena_x) begin
    if (step >= first_smpl && step < last_step) begin
      shadow[step - first_smpl] <= joy_data;
    end
  end

  // last position goes straight in so both words change on one edge
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      pads <= '1;
    end else if (step == last_step) begin
      pads <= frame_to_pads({joy_data, shadow[22:0]});
    end
  end

endmodule

`default_nettype wire

/* src/kbd_pkg.sv */
// ------------------------------
// keyboard types
// scan codes, receiver states, held keys
// ------------------------------

`default_nettype none

package kbd_pkg;

  typedef logic [7:0] scan_code_t;

  typedef struct packed {
    scan_code_t code;
    logic       valid;
    logic       err;
  } kbd_evt_t;

  typedef enum logic [1:0] {
    idle,
    shift,
    check
  } ps2_state_t;

  // one flag per mapped key, high while held
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic space;
    logic key1;
    logic key2;
    logic key5;
    logic f3;
  } key_held_t;

  // set 2 prefixes
  localparam scan_code_t sc_break = 8'hF0;
  localparam scan_code_t sc_ext   = 8'hE0;

  // mapped keys
  localparam scan_code_t sc_up    = 8'h75;
  localparam scan_code_t sc_down  = 8'h72;
  localparam scan_code_t sc_left  = 8'h6B;
  localparam scan_code_t sc_right = 8'h74;
  localparam scan_code_t sc_space = 8'h29;
  localparam scan_code_t sc_key1  = 8'h16;
  localparam scan_code_t sc_key2  = 8'h1E;
  localparam scan_code_t sc_key5  = 8'h2E;
  localparam scan_code_t sc_f3    = 8'h04;

endpackage

`default_nettype wire

/* src/ps2_rx.sv */
// ------------------------------
// PS/2 keyboard receiver
// synchronizes the lines, shifts in 11-bit frames
// and flags start, parity or stop errors
// ------------------------------

`timescale 1ns/100ps
`include "input_cfg.svh"
`default_nettype none

module ps2_rx (
  input  wire logic        ena_x,
  input  wire logic        pll_lckd,
  input  wire logic        ps2_clk,
  input  wire logic        ps2_data,
  output kbd_pkg::kbd_evt_t evt
);
  import kbd_pkg::*;

  localparam int tmr_w = $clog2(`PS2_TIMEOUT + 1);
  localparam int cnt_w = $clog2(`PS2_FRAME_BITS + 1);
  localparam int top   = `PS2_FRAME_BITS - 1;

  logic [1:0]       clk_sync;
  logic [1:0]       data_sync;
  logic             clk_prev;
  logic             clk_fall;
  logic             frame_ok;
  ps2_state_t       state;
  logic [cnt_w-1:0] bit_cnt;
  logic [tmr_w-1:0] idle_tmr;
  logic [top:0]     frame;
  scan_code_t       code_q;
  logic             valid_q;
  logic             err_q;

  // two flops per line, idle level is high
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[1];

  // start low, stop high, odd parity over data and parity bit
  assign frame_ok = ~frame[0] & frame[top] & (^frame[top-1:1]);

  // ------------------------------
  // frame FSM
  // ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state    <= idle;
      bit_cnt  <= '0;
      idle_tmr <= '0;
      valid_q  <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      case (state)
        idle: begin
          idle_tmr <= '0;
          if (clk_fall) begin
            bit_cnt <= cnt_w'(1);
            state   <= shift;
          end
        end
        shift: begin
          if (clk_fall) begin
            idle_tmr <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == cnt_w'(top)) begin
              state <= check;
            end
          end else if (idle_tmr == tmr_w'(`PS2_TIMEOUT - 1)) begin
            // stalled frame, drop silently
            state <= idle;
          end else begin
            idle_tmr <= idle_tmr + 1'b1;
          end
        end
        check: begin
          valid_q <= frame_ok;
          err_q   <= ~frame_ok;
          state   <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // bits arrive lsb first, start bit ends up in frame[0]
  always_ff @(posedge ena_x) begin
    if (clk_fall && state != check) begin
      frame <= {data_sync[1], frame[top:1]};
    end
    if (state == check) begin
      code_q <= frame[8:1];
    end
  end

  assign evt = '{code: code_q, valid: valid_q, err: err_q};

endmodule

`default_nettype wire
